// File: Makefile
VERILATOR ?= verilator
TOP       ?= tb_mem_subsystem
OBJ_DIR   ?= obj_dir
FILELIST  ?= compile.f
VFLAGS    ?= --binary --timing --assert --timescale 1ns/1ps -j 0
PASS_MSG  ?= Test passed

SRCS := $(wildcard design/*.sv sim/*.sv)
BIN  := $(OBJ_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile: $(BIN)

$(BIN): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(BIN)
	@out="$$($(BIN) 2>&1)"; echo "$$out"; echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

// File: compile.f
design/soc_bus_pkg.sv
design/wb_addr_decoder.sv
design/mem_arbiter.sv
design/word_memory.sv
design/dma_copy_engine.sv
design/mem_subsystem_top.sv
sim/mem_subsystem_checker.sv
sim/tb_mem_subsystem.sv

// File: design/dma_copy_engine.sv
`timescale 1ns/1ps

module dma_copy_engine import soc_bus_pkg::*; (
    input  logic  clk,
    input  logic  rst,
    // Register port from the decoder
    input  logic  reg_stb_i,
    input  logic  reg_we_i,
    input  addr_t reg_adr_i,
    input  word_t reg_dat_i,
    output logic  reg_ack_o,
    output word_t reg_dat_o,
    // Memory master toward the arbiter
    output logic  mem_stb_o,
    output logic  mem_we_o,
    output sel_t  mem_sel_o,
    output addr_t mem_adr_o,
    output word_t mem_dat_o,
    input  logic  mem_ack_i,
    input  word_t mem_dat_i,
    output logic  irq_o
);

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_CHECK,
        ST_READ,
        ST_WRITE
    } state_t;

    state_t     state;
    logic       busy;
    logic       done;
    logic       reg_wr;
    logic       start;
    logic [3:0] ofs;
    addr_t      src_q;
    addr_t      dst_q;
    word_t      len_q;
    addr_t      src_ptr;
    addr_t      dst_ptr;
    word_t      cnt;
    word_t      data_q;
    word_t      stat;

    assign ofs    = reg_adr_i[3:0];
    assign reg_wr = reg_stb_i & ~reg_ack_o & reg_we_i;
    assign start  = reg_wr && (ofs == DMA_CTRL_OFS) && reg_dat_i[0] && !busy;

    always_comb begin
        stat                = '0;
        stat[DMA_STAT_BUSY] = busy;
        stat[DMA_STAT_DONE] = done;
    end

    // Register block and copy FSM
    always_ff @(posedge clk) begin
        if (rst) begin
            reg_ack_o <= 1'b0;
            src_q     <= '0;
            dst_q     <= '0;
            len_q     <= '0;
            busy      <= 1'b0;
            done      <= 1'b0;
            state     <= ST_IDLE;
        end else begin
            reg_ack_o <= reg_stb_i & ~reg_ack_o;
            // Setup registers are frozen during a copy
            if (reg_wr && !busy) begin
                case (ofs)
                    DMA_SRC_OFS: src_q <= reg_dat_i;
                    DMA_DST_OFS: dst_q <= reg_dat_i;
                    DMA_LEN_OFS: len_q <= reg_dat_i;
                    default: ;
                endcase
            end
            if (start) begin
                busy  <= 1'b1;
                done  <= 1'b0;
                state <= ST_CHECK;
            end else begin
                case (state)
                    // Also the one idle cycle between words
                    ST_CHECK: begin
                        if (cnt == '0) begin
                            busy  <= 1'b0;
                            done  <= 1'b1;
                            state <= ST_IDLE;
                        end else begin
                            state <= ST_READ;
                        end
                    end
                    ST_READ: if (mem_ack_i) state <= ST_WRITE;
                    ST_WRITE: if (mem_ack_i) state <= ST_CHECK;
                    default: ;
                endcase
            end
        end
    end

    // Working pointers, held word and register read data
    always_ff @(posedge clk) begin
        if (start) begin
            src_ptr <= src_q;
            dst_ptr <= dst_q;
            cnt     <= len_q;
        end else if (state == ST_WRITE && mem_ack_i) begin
            src_ptr <= src_ptr + addr_t'(4);
            dst_ptr <= dst_ptr + addr_t'(4);
            cnt     <= cnt - word_t'(1);
        end
        if (state == ST_READ && mem_ack_i) begin
            data_q <= mem_dat_i;
        end
        case (ofs)
            DMA_SRC_OFS: reg_dat_o <= src_q;
            DMA_DST_OFS: reg_dat_o <= dst_q;
            DMA_LEN_OFS: reg_dat_o <= len_q;
            default:     reg_dat_o <= stat;
        endcase
    end

    assign mem_stb_o = (state == ST_READ) || (state == ST_WRITE);
    assign mem_we_o  = (state == ST_WRITE);
    assign mem_sel_o = '1;
    assign mem_adr_o = (state == ST_WRITE) ? dst_ptr : src_ptr;
    assign mem_dat_o = data_q;

    assign irq_o = done;

endmodule

// File: design/mem_arbiter.sv
`timescale 1ns/1ps

module mem_arbiter import soc_bus_pkg::*; (
    input  logic  clk,
    input  logic  rst,
    // DMA master
    input  logic  dma_stb_i,
    input  logic  dma_we_i,
    input  sel_t  dma_sel_i,
    input  addr_t dma_adr_i,
    input  word_t dma_dat_i,
    output logic  dma_ack_o,
    output word_t dma_dat_o,
    // CPU master
    input  logic  cpu_stb_i,
    input  logic  cpu_we_i,
    input  sel_t  cpu_sel_i,
    input  addr_t cpu_adr_i,
    input  word_t cpu_dat_i,
    output logic  cpu_ack_o,
    output word_t cpu_dat_o,
    // Memory port
    output logic  mem_stb_o,
    output logic  mem_we_o,
    output sel_t  mem_sel_o,
    output addr_t mem_adr_o,
    output word_t mem_dat_o,
    input  logic  mem_ack_i,
    input  word_t mem_dat_i
);

    logic busy;
    logic owner_dma;
    logic pick_dma;

    // Locked owner while busy, otherwise DMA first
    assign pick_dma = busy ? owner_dma : dma_stb_i;

    always_ff @(posedge clk) begin
        if (rst) begin
            busy      <= 1'b0;
            owner_dma <= 1'b0;
        end else if (busy) begin
            if (mem_ack_i) begin
                busy <= 1'b0;
            end
        end else if (dma_stb_i || cpu_stb_i) begin
            busy      <= 1'b1;
            owner_dma <= dma_stb_i;
        end
    end

    always_comb begin
        if (pick_dma) begin
            mem_stb_o = dma_stb_i;
            mem_we_o  = dma_we_i;
            mem_sel_o = dma_sel_i;
            mem_adr_o = dma_adr_i;
            mem_dat_o = dma_dat_i;
        end else begin
            mem_stb_o = cpu_stb_i;
            mem_we_o  = cpu_we_i;
            mem_sel_o = cpu_sel_i;
            mem_adr_o = cpu_adr_i;
            mem_dat_o = cpu_dat_i;
        end
    end

    // Reply goes to the owner only
    assign dma_ack_o = mem_ack_i & busy & owner_dma;
    assign cpu_ack_o = mem_ack_i & busy & ~owner_dma;
    assign dma_dat_o = owner_dma ? mem_dat_i : '0;
    assign cpu_dat_o = owner_dma ? '0 : mem_dat_i;

endmodule

// File: design/mem_subsystem_top.sv
`timescale 1ns/1ps

module mem_subsystem_top import soc_bus_pkg::*; #(
    parameter int MEM_WORDS = 4096
) (
    input  logic  clk,
    input  logic  rst,
    input  logic  wbs_stb_i,
    input  logic  wbs_cyc_i,
    input  logic  wbs_we_i,
    input  sel_t  wbs_sel_i,
    input  addr_t wbs_adr_i,
    input  word_t wbs_dat_i,
    output logic  wbs_ack_o,
    output word_t wbs_dat_o,
    output logic  irq_o
);

    // CPU side after decode
    logic  cpu_mem_stb;
    logic  cpu_mem_ack;
    word_t cpu_mem_dat;
    logic  dma_reg_stb;
    logic  dma_reg_ack;
    word_t dma_reg_dat;

    // DMA memory master
    logic  dma_mem_stb;
    logic  dma_mem_we;
    sel_t  dma_mem_sel;
    addr_t dma_mem_adr;
    word_t dma_mem_wdat;
    logic  dma_mem_ack;
    word_t dma_mem_rdat;

    // Granted memory port
    logic  mem_stb;
    logic  mem_we;
    sel_t  mem_sel;
    addr_t mem_adr;
    word_t mem_wdat;
    logic  mem_ack;
    word_t mem_rdat;

    wb_addr_decoder #(
        .MEM_WORDS (MEM_WORDS)
    ) u_decoder (
        .clk       (clk),
        .rst       (rst),
        .cpu_stb_i (wbs_stb_i),
        .cpu_cyc_i (wbs_cyc_i),
        .cpu_we_i  (wbs_we_i),
        .cpu_sel_i (wbs_sel_i),
        .cpu_adr_i (wbs_adr_i),
        .cpu_dat_i (wbs_dat_i),
        .cpu_ack_o (wbs_ack_o),
        .cpu_dat_o (wbs_dat_o),
        .mem_stb_o (cpu_mem_stb),
        .mem_ack_i (cpu_mem_ack),
        .mem_dat_i (cpu_mem_dat),
        .dma_stb_o (dma_reg_stb),
        .dma_ack_i (dma_reg_ack),
        .dma_dat_i (dma_reg_dat)
    );

    dma_copy_engine u_dma (
        .clk       (clk),
        .rst       (rst),
        .reg_stb_i (dma_reg_stb),
        .reg_we_i  (wbs_we_i),
        .reg_adr_i (wbs_adr_i),
        .reg_dat_i (wbs_dat_i),
        .reg_ack_o (dma_reg_ack),
        .reg_dat_o (dma_reg_dat),
        .mem_stb_o (dma_mem_stb),
        .mem_we_o  (dma_mem_we),
        .mem_sel_o (dma_mem_sel),
        .mem_adr_o (dma_mem_adr),
        .mem_dat_o (dma_mem_wdat),
        .mem_ack_i (dma_mem_ack),
        .mem_dat_i (dma_mem_rdat),
        .irq_o     (irq_o)
    );

    mem_arbiter u_arbiter (
        .clk       (clk),
        .rst       (rst),
        .dma_stb_i (dma_mem_stb),
        .dma_we_i  (dma_mem_we),
        .dma_sel_i (dma_mem_sel),
        .dma_adr_i (dma_mem_adr),
        .dma_dat_i (dma_mem_wdat),
        .dma_ack_o (dma_mem_ack),
        .dma_dat_o (dma_mem_rdat),
        .cpu_stb_i (cpu_mem_stb),
        .cpu_we_i  (wbs_we_i),
        .cpu_sel_i (wbs_sel_i),
        .cpu_adr_i (wbs_adr_i),
        .cpu_dat_i (wbs_dat_i),
        .cpu_ack_o (cpu_mem_ack),
        .cpu_dat_o (cpu_mem_dat),
        .mem_stb_o (mem_stb),
        .mem_we_o  (mem_we),
        .mem_sel_o (mem_sel),
        .mem_adr_o (mem_adr),
        .mem_dat_o (mem_wdat),
        .mem_ack_i (mem_ack),
        .mem_dat_i (mem_rdat)
    );

    word_memory #(
        .MEM_WORDS (MEM_WORDS)
    ) u_memory (
        .clk   (clk),
        .rst   (rst),
        .stb_i (mem_stb),
        .we_i  (mem_we),
        .sel_i (mem_sel),
        .adr_i (mem_adr),
        .dat_i (mem_wdat),
        .ack_o (mem_ack),
        .dat_o (mem_rdat)
    );

endmodule

// File: design/soc_bus_pkg.sv
package soc_bus_pkg;

    // Wishbone bus widths
    localparam int ADDR_W = 32;
    localparam int DATA_W = 32;
    localparam int SEL_W  = DATA_W / 8;

    typedef logic [DATA_W-1:0] word_t;
    typedef logic [ADDR_W-1:0] addr_t;
    typedef logic [SEL_W-1:0]  sel_t;

    // Address map
    localparam addr_t MEM_BASE = 32'h3800_0000;
    localparam addr_t DMA_BASE = 32'h3000_0080;

    // DMA register offsets inside its 16-byte block
    localparam logic [3:0] DMA_SRC_OFS  = 4'h0;
    localparam logic [3:0] DMA_DST_OFS  = 4'h4;
    localparam logic [3:0] DMA_LEN_OFS  = 4'h8;
    localparam logic [3:0] DMA_CTRL_OFS = 4'hC;

    // Status bits in the control register
    localparam int DMA_STAT_BUSY = 0;
    localparam int DMA_STAT_DONE = 1;

endpackage

// File: design/wb_addr_decoder.sv
`timescale 1ns/1ps

module wb_addr_decoder import soc_bus_pkg::*; #(
    parameter int MEM_WORDS = 4096
) (
    input  logic  clk,
    input  logic  rst,
    input  logic  cpu_stb_i,
    input  logic  cpu_cyc_i,
    input  logic  cpu_we_i,
    input  sel_t  cpu_sel_i,
    input  addr_t cpu_adr_i,
    input  word_t cpu_dat_i,
    output logic  cpu_ack_o,
    output word_t cpu_dat_o,
    output logic  mem_stb_o,
    input  logic  mem_ack_i,
    input  word_t mem_dat_i,
    output logic  dma_stb_o,
    input  logic  dma_ack_i,
    input  word_t dma_dat_i
);

    localparam addr_t MEM_SPAN = addr_t'(MEM_WORDS * 4);

    logic  cpu_req;
    logic  mem_hit;
    logic  dma_hit;
    logic  dflt_ack;

    assign cpu_req = cpu_stb_i & cpu_cyc_i;

    // Window compare, memory window scales with MEM_WORDS
    assign mem_hit = (cpu_adr_i >= MEM_BASE) && ((cpu_adr_i - MEM_BASE) < MEM_SPAN);
    assign dma_hit = (cpu_adr_i[ADDR_W-1:4] == DMA_BASE[ADDR_W-1:4]);

    assign mem_stb_o = cpu_req & mem_hit;
    assign dma_stb_o = cpu_req & dma_hit;

    // Default responder for unmapped addresses, one ack per access
    always_ff @(posedge clk) begin
        if (rst) begin
            dflt_ack <= 1'b0;
        end else begin
            dflt_ack <= cpu_req & ~mem_hit & ~dma_hit & ~dflt_ack;
        end
    end

    // Reply mux follows the same window result
    always_comb begin
        if (mem_hit) begin
            cpu_ack_o = mem_ack_i;
            cpu_dat_o = mem_dat_i;
        end else if (dma_hit) begin
            cpu_ack_o = dma_ack_i;
            cpu_dat_o = dma_dat_i;
        end else begin
            cpu_ack_o = dflt_ack;
            cpu_dat_o = '0;
        end
    end

endmodule

// File: design/word_memory.sv
`timescale 1ns/1ps

module word_memory import soc_bus_pkg::*; #(
    parameter int MEM_WORDS = 4096
) (
    input  logic  clk,
    input  logic  rst,
    input  logic  stb_i,
    input  logic  we_i,
    input  sel_t  sel_i,
    input  addr_t adr_i,
    input  word_t dat_i,
    output logic  ack_o,
    output word_t dat_o
);

    localparam int IDX_W = $clog2(MEM_WORDS);

    word_t            mem [MEM_WORDS];
    logic [IDX_W-1:0] idx;
    logic             take;

    // Word index wraps modulo MEM_WORDS
    assign idx  = adr_i[IDX_W+1:2];
    assign take = stb_i & ~ack_o;

    always_ff @(posedge clk) begin
        if (rst) begin
            ack_o <= 1'b0;
        end else begin
            ack_o <= take;
        end
    end

    always_ff @(posedge clk) begin
        if (take) begin
            if (we_i) begin
                for (int b = 0; b < SEL_W; b++) begin
                    if (sel_i[b]) begin
                        mem[idx][8*b +: 8] <= dat_i[8*b +: 8];
                    end
                end
            end
            dat_o <= mem[idx];
        end
    end

endmodule

// File: sim/mem_subsystem_checker.sv
`timescale 1ns/1ps

module mem_subsystem_checker (
    input logic clk,
    input logic rst,
    input logic wbs_ack_i,
    input logic mem_stb_i,
    input logic mem_ack_i,
    input logic dma_ack_i,
    input logic cpu_ack_i
);

    // Number of assertion failures so far
    int unsigned fail_count = 0;

    // One ack per access on the external port
    a_wbs_ack_single: assert property (@(posedge clk) disable iff (rst)
        wbs_ack_i |=> !wbs_ack_i)
        else begin
            $error("wbs_ack_o high in two consecutive cycles");
            fail_count++;
        end

    // Memory only answers a granted strobe
    a_mem_ack_after_stb: assert property (@(posedge clk) disable iff (rst)
        mem_ack_i |-> $past(mem_stb_i))
        else begin
            $error("memory ack without a granted strobe in the cycle before");
            fail_count++;
        end

    a_master_acks_exclusive: assert property (@(posedge clk) disable iff (rst)
        !(dma_ack_i && cpu_ack_i))
        else begin
            $error("arbiter acked the DMA and the CPU together");
            fail_count++;
        end

endmodule

bind mem_subsystem_top mem_subsystem_checker u_checker (
    .clk       (clk),
    .rst       (rst),
    .wbs_ack_i (wbs_ack_o),
    .mem_stb_i (mem_stb),
    .mem_ack_i (mem_ack),
    .dma_ack_i (dma_mem_ack),
    .cpu_ack_i (cpu_mem_ack)
);

// File: sim/tb_mem_subsystem.sv
`timescale 1ns/1ps

module tb_mem_subsystem import soc_bus_pkg::*; ();

    localparam int    LEN_WORDS   = 16;
    localparam int    ACK_LIMIT   = 200;
    localparam int    POLL_LIMIT  = 400;
    localparam addr_t SRC_ADR     = MEM_BASE + 32'h0000_0100;
    localparam addr_t DST_ADR     = MEM_BASE + 32'h0000_0200;
    localparam addr_t DST2_ADR    = MEM_BASE + 32'h0000_0300;
    localparam addr_t SPARE_ADR   = MEM_BASE + 32'h0000_0040;
    localparam addr_t ALIAS_ADR   = MEM_BASE + 32'h0000_1000;
    localparam addr_t BLOCK_BYTES = addr_t'(4 * LEN_WORDS);
    localparam addr_t REG_SRC     = DMA_BASE + addr_t'(DMA_SRC_OFS);
    localparam addr_t REG_DST     = DMA_BASE + addr_t'(DMA_DST_OFS);
    localparam addr_t REG_LEN     = DMA_BASE + addr_t'(DMA_LEN_OFS);
    localparam addr_t REG_CTRL    = DMA_BASE + addr_t'(DMA_CTRL_OFS);
    localparam addr_t UNMAPPED    = 32'h3000_1000;
    localparam word_t SPARE_VAL   = 32'h4c1e_0040;
    localparam word_t ALIAS_VAL   = 32'h3c3c_1000;
    localparam word_t GUARD_VAL   = 32'h5a5a_0001;

    typedef enum logic [2:0] {
        OP_WRITE,
        OP_READ,
        OP_LATENCY,
        OP_STATUS,
        OP_IRQ,
        OP_WAIT
    } op_t;

    typedef struct packed {
        op_t   op;
        addr_t adr;
        word_t dat;
        sel_t  sel;
        word_t exp;
    } row_t;

    logic  clk;
    logic  rst;
    logic  wbs_stb;
    logic  wbs_cyc;
    logic  wbs_we;
    sel_t  wbs_sel;
    addr_t wbs_adr;
    word_t wbs_wdat;
    logic  wbs_ack;
    word_t wbs_rdat;
    logic  irq;
    row_t  rows[$];
    word_t src_vals[LEN_WORDS];

    mem_subsystem_top #(
        .MEM_WORDS (4096)
    ) u_mem_subsystem_top (
        .clk       (clk),
        .rst       (rst),
        .wbs_stb_i (wbs_stb),
        .wbs_cyc_i (wbs_cyc),
        .wbs_we_i  (wbs_we),
        .wbs_sel_i (wbs_sel),
        .wbs_adr_i (wbs_adr),
        .wbs_dat_i (wbs_wdat),
        .wbs_ack_o (wbs_ack),
        .wbs_dat_o (wbs_rdat),
        .irq_o     (irq)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    task automatic abort_run();
        $display("Test failed");
        $fatal(1);
    endtask

    // Bound assertions stop the run at the next falling edge
    always @(negedge clk) begin
        if (u_mem_subsystem_top.u_checker.fail_count != 0) begin
            $display("A bus handshake assertion failed");
            abort_run();
        end
    end

    task automatic check_word(input string name, input word_t got, input word_t exp);
        if (got !== exp) begin
            $display("Fail %s: got %h, expected %h", name, got, exp);
            abort_run();
        end
    endtask

    task automatic check_flag(input string name, input bit got, input bit exp);
        if (got !== exp) begin
            $display("Fail %s: got %h, expected %h", name, got, exp);
            abort_run();
        end
    endtask

    // Expected word after a write with byte selects
    function automatic word_t merge_bytes(word_t old_w, word_t new_w, sel_t sel);
        word_t res;
        res = old_w;
        for (int b = 0; b < SEL_W; b++) begin
            if (sel[b]) begin
                res[8*b +: 8] = new_w[8*b +: 8];
            end
        end
        return res;
    endfunction

    // One classic cycle, ack sampled at the falling edge
    task automatic wb_cycle(input logic we, input addr_t adr, input word_t dat, input sel_t sel,
                            output word_t rdata, output int cycles);
        logic ack_seen;
        wbs_we   = we;
        wbs_adr  = adr;
        wbs_wdat = dat;
        wbs_sel  = sel;
        wbs_stb  = 1'b1;
        wbs_cyc  = 1'b1;
        cycles   = 0;
        ack_seen = 1'b0;
        while (!ack_seen) begin
            @(negedge clk);
            cycles++;
            ack_seen = (wbs_ack === 1'b1);
            if (!ack_seen && cycles >= ACK_LIMIT) begin
                $display("No ack for address %h after %0d cycles", adr, ACK_LIMIT);
                abort_run();
            end
        end
        rdata = wbs_rdat;
        @(posedge clk);
        #1;
        wbs_stb = 1'b0;
        wbs_cyc = 1'b0;
        wbs_we  = 1'b0;
    endtask

    task automatic bus_write(input addr_t adr, input word_t dat, input sel_t sel);
        word_t echo;
        int    cyc;
        wb_cycle(1'b1, adr, dat, sel, echo, cyc);
    endtask

    task automatic bus_read(input addr_t adr, output word_t rdata, output int cycles);
        wb_cycle(1'b0, adr, '0, 4'hF, rdata, cycles);
    endtask

    // Poll the control register until done
    task automatic wait_done();
        word_t stat;
        int    cyc;
        int    polls;
        polls = 0;
        bus_read(REG_CTRL, stat, cyc);
        while (stat[DMA_STAT_DONE] !== 1'b1) begin
            polls++;
            if (polls >= POLL_LIMIT) begin
                $display("DMA done bit not set after %0d status polls", POLL_LIMIT);
                abort_run();
            end
            bus_read(REG_CTRL, stat, cyc);
        end
    endtask

    function automatic void push_row(op_t op, addr_t adr, word_t dat, sel_t sel, word_t exp);
        rows.push_back('{op, adr, dat, sel, exp});
    endfunction

    function automatic void build_table();
        word_t merged;
        merged = merge_bytes(32'h1122_3344, 32'haabb_ccdd, 4'b0011);
        // Plain and partial memory writes
        push_row(OP_WRITE, MEM_BASE, 32'h1122_3344, 4'hF, '0);
        push_row(OP_WRITE, MEM_BASE + 32'h4, 32'ha5a5_0f0f, 4'hF, '0);
        push_row(OP_READ, MEM_BASE, '0, 4'hF, 32'h1122_3344);
        push_row(OP_READ, MEM_BASE + 32'h4, '0, 4'hF, 32'ha5a5_0f0f);
        push_row(OP_WRITE, MEM_BASE, 32'haabb_ccdd, 4'b0011, '0);
        push_row(OP_READ, MEM_BASE, '0, 4'hF, merged);
        push_row(OP_LATENCY, MEM_BASE + 32'h4, '0, 4'hF, 32'ha5a5_0f0f);
        push_row(OP_WRITE, SPARE_ADR, SPARE_VAL, 4'hF, '0);
        // Same word index as the unmapped address
        push_row(OP_WRITE, ALIAS_ADR, ALIAS_VAL, 4'hF, '0);
        // Setup registers and the unmapped responder
        push_row(OP_WRITE, REG_SRC, SRC_ADR, 4'hF, '0);
        push_row(OP_WRITE, REG_DST, DST_ADR, 4'hF, '0);
        push_row(OP_WRITE, REG_LEN, word_t'(LEN_WORDS), 4'hF, '0);
        push_row(OP_READ, REG_SRC, '0, 4'hF, SRC_ADR);
        push_row(OP_READ, REG_DST, '0, 4'hF, DST_ADR);
        push_row(OP_READ, REG_LEN, '0, 4'hF, word_t'(LEN_WORDS));
        push_row(OP_READ, UNMAPPED, '0, 4'hF, '0);
        push_row(OP_WRITE, UNMAPPED, 32'hdead_beef, 4'hF, '0);
        push_row(OP_READ, UNMAPPED, '0, 4'hF, '0);
        // Targets an unmapped write could leak into
        push_row(OP_READ, ALIAS_ADR, '0, 4'hF, ALIAS_VAL);
        push_row(OP_READ, REG_SRC, '0, 4'hF, SRC_ADR);
        // Source block, guard words just past both destinations
        for (int i = 0; i < LEN_WORDS; i++) begin
            push_row(OP_WRITE, SRC_ADR + addr_t'(4 * i), src_vals[i], 4'hF, '0);
        end
        push_row(OP_WRITE, DST_ADR + BLOCK_BYTES, GUARD_VAL, 4'hF, '0);
        push_row(OP_WRITE, DST2_ADR + BLOCK_BYTES, GUARD_VAL, 4'hF, '0);
        // First copy
        push_row(OP_WRITE, REG_CTRL, 32'h1, 4'hF, '0);
        push_row(OP_WAIT, REG_CTRL, '0, 4'hF, '0);
        push_row(OP_IRQ, '0, '0, 4'hF, 32'h1);
        push_row(OP_STATUS, REG_CTRL, '0, 4'hF, 32'h2);
        for (int i = 0; i < LEN_WORDS; i++) begin
            push_row(OP_READ, DST_ADR + addr_t'(4 * i), '0, 4'hF, src_vals[i]);
        end
        push_row(OP_READ, DST_ADR + BLOCK_BYTES, '0, 4'hF, GUARD_VAL);
        // Second copy, CPU traffic and ignored writes while busy
        push_row(OP_WRITE, REG_DST, DST2_ADR, 4'hF, '0);
        push_row(OP_WRITE, REG_CTRL, 32'h1, 4'hF, '0);
        push_row(OP_READ, SPARE_ADR, '0, 4'hF, SPARE_VAL);
        // Source word 0 changes after it was copied
        push_row(OP_WRITE, SRC_ADR, ~src_vals[0], 4'hF, '0);
        push_row(OP_WRITE, REG_LEN, 32'd32, 4'hF, '0);
        push_row(OP_WRITE, REG_CTRL, 32'h1, 4'hF, '0);
        push_row(OP_STATUS, REG_CTRL, '0, 4'hF, 32'h1);
        push_row(OP_WAIT, REG_CTRL, '0, 4'hF, '0);
        push_row(OP_READ, REG_LEN, '0, 4'hF, word_t'(LEN_WORDS));
        for (int i = 0; i < LEN_WORDS; i++) begin
            push_row(OP_READ, DST2_ADR + addr_t'(4 * i), '0, 4'hF, src_vals[i]);
        end
        push_row(OP_READ, DST2_ADR + BLOCK_BYTES, '0, 4'hF, GUARD_VAL);
        // Zero length leaves the destination alone
        push_row(OP_WRITE, REG_SRC, SPARE_ADR, 4'hF, '0);
        push_row(OP_WRITE, REG_DST, DST_ADR, 4'hF, '0);
        push_row(OP_WRITE, REG_LEN, '0, 4'hF, '0);
        push_row(OP_WRITE, REG_CTRL, 32'h1, 4'hF, '0);
        push_row(OP_WAIT, REG_CTRL, '0, 4'hF, '0);
        push_row(OP_IRQ, '0, '0, 4'hF, 32'h1);
        push_row(OP_READ, DST_ADR, '0, 4'hF, src_vals[0]);
        // A new start clears done and irq
        push_row(OP_WRITE, REG_LEN, 32'h1, 4'hF, '0);
        push_row(OP_WRITE, REG_CTRL, 32'h1, 4'hF, '0);
        push_row(OP_IRQ, '0, '0, 4'hF, 32'h0);
        push_row(OP_STATUS, REG_CTRL, '0, 4'hF, 32'h1);
        push_row(OP_WAIT, REG_CTRL, '0, 4'hF, '0);
        push_row(OP_IRQ, '0, '0, 4'hF, 32'h1);
        push_row(OP_READ, DST_ADR, '0, 4'hF, SPARE_VAL);
        push_row(OP_READ, DST_ADR + 32'h4, '0, 4'hF, src_vals[1]);
    endfunction

    task automatic apply_row(input row_t r);
        word_t rd;
        int    cyc;
        case (r.op)
            OP_WRITE: bus_write(r.adr, r.dat, r.sel);
            OP_READ: begin
                bus_read(r.adr, rd, cyc);
                check_word($sformatf("wbs_dat_o at %h", r.adr), rd, r.exp);
            end
            OP_LATENCY: begin
                bus_read(r.adr, rd, cyc);
                check_flag("wbs_ack_o in cycle 2", cyc == 2, 1'b1);
                check_word($sformatf("wbs_dat_o at %h", r.adr), rd, r.exp);
            end
            OP_STATUS: begin
                bus_read(r.adr, rd, cyc);
                check_flag("status busy", rd[DMA_STAT_BUSY], r.exp[DMA_STAT_BUSY]);
                check_flag("status done", rd[DMA_STAT_DONE], r.exp[DMA_STAT_DONE]);
            end
            OP_IRQ: check_flag("irq_o", irq, r.exp[0]);
            OP_WAIT: wait_done();
            default: ;
        endcase
    endtask

    initial begin
        rst      = 1'b1;
        wbs_stb  = 1'b0;
        wbs_cyc  = 1'b0;
        wbs_we   = 1'b0;
        wbs_sel  = '0;
        wbs_adr  = '0;
        wbs_wdat = '0;
        // Seed once, then draw the source block
        void'($urandom(32'h603c_d4f2));
        for (int i = 0; i < LEN_WORDS; i++) begin
            src_vals[i] = $urandom();
        end
        build_table();
        repeat (2) @(posedge clk);
        #1;
        rst = 1'b0;
        foreach (rows[i]) begin
            apply_row(rows[i]);
        end
        if (u_mem_subsystem_top.u_checker.fail_count != 0) begin
            $display("A bus handshake assertion failed");
            abort_run();
        end else begin
            $display("Test passed");
            $finish;
        end
    end

endmodule
